/* list.f */
design/cpu_pkg.sv
design/program_counter.sv
design/control_block.sv
design/datapath.sv
design/cpu_top.sv
tests/cpu_tb.sv

/* tests/cpu_tb.sv */
// directed tests for cpu_top with program memory model, reference interpreter and compare tasks
`timescale 1ns/100ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    logic [7:0] ui_in;
    logic [7:0] uo_out;
    logic [7:0] uio_in;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;
    logic       ena;
    logic       clk;
    logic       rst;

    byte_t  mem [16];   // external program memory
    integer seed = 59908;
    int     checks = 0;
    int     errors = 0;

    cpu_top UUT (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst     (rst)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // memory answers on the falling edge before the read edge
    initial begin
        forever begin
            @(negedge clk);
            ui_in = $isunknown(uio_out[3:0]) ? 8'h00 : mem[uio_out[3:0]];
        end
    end

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%02h got 0x%02h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%01h got 0x%01h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%01h got 0x%01h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic byte_t encode(input opcode_t op, input addr_t a);
        return {op, a};  // opcode high nibble, address low nibble
    endfunction

    task automatic clear_mem();
        for (int i = 0; i < 16; i++) begin
            mem[i] = 8'h00;
        end
    endtask

    // instruction-level model with one pass per instruction
    task automatic interpret(output byte_t out_v, output addr_t halt_a);
        addr_t pc;
        addr_t fetch_a;
        byte_t acc;
        byte_t ins;
        logic  done;
        int    steps;
        pc = '0;
        acc = '0;
        out_v = '0;
        halt_a = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 64) begin
            fetch_a = pc;
            ins = mem[pc];
            pc = pc + 4'd1;  // wraps at 16
            case (ins[7:4])
                OP_LDA: acc = mem[ins[3:0]];
                OP_ADD: acc = acc + mem[ins[3:0]];
                OP_SUB: acc = acc - mem[ins[3:0]];
                OP_JMP: pc = ins[3:0];
                OP_OUT: out_v = acc;
                OP_HLT: begin
                    halt_a = fetch_a;  // mar still points at the hlt byte
                    done = 1'b1;
                end
                default: ;  // nop
            endcase
            steps++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_halt();
        int n;
        for (n = 0; n < 200 && uio_out[7] !== 1'b1; n++) begin
            @(negedge clk);
        end
        if (uio_out[7] !== 1'b1) begin
            errors++;
            $display("timeout: cpu did not halt within 200 cycles at %0t", $time);
        end
    endtask

    // reset, run to halt, compare with the interpreter
    task automatic run_and_check(input string label);
        byte_t exp_out;
        addr_t exp_addr;
        interpret(exp_out, exp_addr);
        apply_reset();
        wait_halt();
        check_byte({label, " uo_out"}, exp_out, uo_out);
        check_addr({label, " mem_addr"}, exp_addr, uio_out[3:0]);
    endtask

    task automatic test_lda_out();
        clear_mem();
        mem[0] = encode(OP_LDA, 4'd9);
        mem[1] = encode(OP_OUT, 4'd0);
        mem[2] = encode(OP_HLT, 4'd0);
        mem[9] = 8'h5A;
        run_and_check("lda_out");
        check_byte("lda_out uo_out const", 8'h5A, uo_out);
        check_addr("lda_out mem_addr const", 4'd2, uio_out[3:0]);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        rst = 1'b1;
        repeat (10) @(negedge clk);
        check_byte("reset uo_out", 8'h00, uo_out);  // still in reset
        check_flag("reset halted", 1'b0, uio_out[7]);
        check_addr("reset mem_addr", 4'd0, uio_out[3:0]);
        check_byte("reset uio_oe", 8'hff, uio_oe);
        rst = 1'b0;
        @(negedge clk);  // one cycle out with T1 done
        check_byte("post reset uo_out", 8'h00, uo_out);
        check_flag("post reset halted", 1'b0, uio_out[7]);
        check_addr("post reset mem_addr", 4'd0, uio_out[3:0]);
        check_byte("post reset uio_oe", 8'hff, uio_oe);
        @(negedge clk);  // T3 fetch raises the read strobe
        check_flag("fetch strobe", 1'b1, uio_out[4]);
        check_flag("uio_out[5]", 1'b0, uio_out[5]);
        check_flag("uio_out[6]", 1'b0, uio_out[6]);
    endtask

    task automatic test_add_sub();
        clear_mem();
        mem[0] = encode(OP_LDA, 4'd12);
        mem[1] = encode(OP_ADD, 4'd13);
        mem[2] = encode(OP_SUB, 4'd14);
        mem[3] = encode(OP_OUT, 4'd0);
        mem[4] = encode(OP_HLT, 4'd0);
        mem[12] = 8'hF0;
        mem[13] = 8'h20;
        mem[14] = 8'h35;
        run_and_check("add_sub");
        check_byte("add_sub uo_out const", 8'hDB, uo_out);
        // intermediate sum wraps past 0xff
        mem[2] = encode(OP_OUT, 4'd0);
        mem[3] = encode(OP_HLT, 4'd0);
        run_and_check("add_mid");
        check_byte("add_mid uo_out const", 8'h10, uo_out);
    endtask

    task automatic test_jmp();
        clear_mem();
        mem[0] = encode(OP_JMP, 4'd4);
        mem[1] = encode(OP_OUT, 4'd0);  // would publish 0
        mem[2] = encode(OP_HLT, 4'd0);
        mem[4] = encode(OP_LDA, 4'd12);
        mem[5] = encode(OP_OUT, 4'd0);
        mem[6] = encode(OP_HLT, 4'd0);
        mem[12] = 8'h6C;
        run_and_check("jmp");
        check_byte("jmp uo_out const", 8'h6C, uo_out);
    endtask

    task automatic test_random_arith();
        opcode_t op;
        for (int p = 0; p < 20; p++) begin
            clear_mem();
            mem[0] = encode(OP_LDA, 4'd8);
            for (int k = 1; k <= 3; k++) begin
                op = ($random(seed) & 1) ? OP_SUB : OP_ADD;
                mem[k] = encode(op, addr_t'(4'd8 + k));  // operands at 9..11
            end
            mem[4] = encode(OP_OUT, 4'd0);
            mem[5] = encode(OP_HLT, 4'd0);
            for (int d = 8; d < 12; d++) begin
                mem[d] = byte_t'($random(seed));
            end
            run_and_check($sformatf("random %0d", p));
        end
    endtask

    task automatic test_halt_holds();
        test_lda_out();
        repeat (50) begin
            @(negedge clk);
            check_byte("halt uo_out", 8'h5A, uo_out);
            check_addr("halt mem_addr", 4'd2, uio_out[3:0]);
            check_flag("halt strobe", 1'b0, uio_out[4]);
            check_flag("halt halted", 1'b1, uio_out[7]);
        end
    endtask

    initial begin
        rst = 1'b1;  // reset from time zero
        ui_in = 8'h00;
        uio_in = 8'h00;
        ena = 1'b1;
        clear_mem();
        test_lda_out();
        test_reset_state();
        test_add_sub();
        test_jmp();
        test_random_arith();
        test_halt_holds();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/cpu_top.sv */
// cpu_top: pin map around program_counter, control_block and datapath
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire [7:0] ui_in,    // program memory byte for the current address
    output wire [7:0] uo_out,   // output register
    input  wire [7:0] uio_in,   // no inputs on this design
    output wire [7:0] uio_out,  // address, read strobe, halted
    output wire [7:0] uio_oe,   // all outputs
    input  wire       ena,      // accepted, no function
    input  wire       clk,
    input  wire       rst
);

    ctrl_word_t ctrl;
    opcode_t    opcode;
    addr_t      pc_value;
    addr_t      mem_addr;
    byte_t      bus;
    byte_t      out_value;
    logic       halted;

    program_counter u_pc (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .bus      (bus),
        .pc_value (pc_value)
    );

    control_block u_cb (
        .clk    (clk),
        .rst    (rst),
        .opcode (opcode),
        .ctrl   (ctrl),
        .halted (halted)
    );

    datapath u_dp (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .pc_value  (pc_value),
        .mem_data  (ui_in),     // same-cycle read
        .bus       (bus),
        .mem_addr  (mem_addr),
        .opcode    (opcode),
        .out_value (out_value)
    );

    assign uo_out  = out_value;
    assign uio_out = {halted, 2'b00, ctrl.ce, mem_addr};  // [7] halted, [4] strobe, [3:0] addr
    assign uio_oe  = 8'hff;

endmodule

`default_nettype wire

/* design/datapath.sv */
// bus mux, mar, ir, accumulator, b register, adder-subtractor and output register
`timescale 1ns/100ps
`default_nettype none

module datapath import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire ctrl_word_t ctrl,
    input  wire addr_t pc_value,  // from program_counter
    input  wire byte_t mem_data,  // combinational read of mem_addr
    output byte_t      bus,
    output addr_t      mem_addr,
    output opcode_t    opcode,
    output byte_t      out_value
);

    addr_t mar;
    byte_t ir;
    byte_t acc;
    byte_t b_reg;
    byte_t out_reg;
    byte_t alu_out;

    // mod 256 with no carry or borrow kept
    assign alu_out = ctrl.su ? acc - b_reg : acc + b_reg;

    // enable-driven mux stands in for a tristate bus
    always_comb begin
        bus = '0;  // floats low when nobody drives
        if (ctrl.ep) begin
            bus = {4'h0, pc_value};
        end else if (ctrl.ce) begin
            bus = mem_data;
        end else if (ctrl.ei) begin
            bus = {4'h0, ir[3:0]};  // address nibble only
        end else if (ctrl.ea) begin
            bus = acc;
        end else if (ctrl.eu) begin
            bus = alu_out;
        end
    end

    // mar holds only a 16 byte address
    always_ff @(posedge clk) begin
        if (rst) begin
            mar <= '0;
        end else if (ctrl.lm) begin
            mar <= addr_t'(bus[3:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ir <= '0;  // decodes as LDA 0 until first fetch
        end else if (ctrl.li) begin
            ir <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (ctrl.la) begin
            acc <= bus;  // from memory or adder
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_reg <= '0;
        end else if (ctrl.lb) begin
            b_reg <= bus;
        end
    end

    // output register feeds the pins directly
    always_ff @(posedge clk) begin
        if (rst) begin
            out_reg <= '0;
        end else if (ctrl.lo) begin
            out_reg <= bus;
        end
    end

    assign mem_addr  = mar;
    assign opcode    = opcode_t'(ir[7:4]);
    assign out_value = out_reg;

    // loading acc and b together would lose an operand
    assert property (@(posedge clk) disable iff (rst)
        !(ctrl.la && ctrl.lb))
        else $error("acc and b loaded together");

endmodule

`default_nettype wire

/* design/control_block.sv */
// control_block: T1..T6 ring, microcode decoder, halt latch and control assertions
`timescale 1ns/100ps
`default_nettype none

module control_block import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire opcode_t opcode,  // from ir upper nibble
    output ctrl_word_t ctrl,      // one level per timing state
    output logic       halted     // sticky until reset
);

    tstate_t    ring;
    tstate_t    ring_next;
    ctrl_word_t dec;    // raw microcode before the halt gate

    // ring order
    always_comb begin
        case (ring)
            T1:      ring_next = T2;
            T2:      ring_next = T3;
            T3:      ring_next = T4;
            T4:      ring_next = T5;
            T5:      ring_next = T6;
            default: ring_next = T1;  // T6 wraps
        endcase
    end

    // ring freezes once halted
    always_ff @(posedge clk) begin
        if (rst) begin
            ring <= T1;
        end else if (!halted) begin
            ring <= ring_next;
        end
    end

    // microcode, fetch is the same for every opcode
    always_comb begin
        dec = CTRL_IDLE;
        case (ring)
            T1: begin
                dec.ep = 1'b1;  // pc -> mar
                dec.lm = 1'b1;
            end
            T2: dec.cp = 1'b1;
            T3: begin
                dec.ce = 1'b1;  // mem -> ir
                dec.li = 1'b1;
            end
            T4: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB: begin
                        dec.ei = 1'b1;  // operand address -> mar
                        dec.lm = 1'b1;
                    end
                    OP_OUT: begin
                        dec.ea = 1'b1;
                        dec.lo = 1'b1;
                    end
                    OP_JMP: begin
                        dec.ei = 1'b1;  // target -> pc
                        dec.lp = 1'b1;
                    end
                    OP_HLT:  dec.hlt = 1'b1;
                    default: ;          // nop, just burn the state
                endcase
            end
            T5: begin
                case (opcode)
                    OP_LDA: begin
                        dec.ce = 1'b1;
                        dec.la = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        dec.ce = 1'b1;  // operand -> b
                        dec.lb = 1'b1;
                    end
                    default: ;
                endcase
            end
            T6: begin
                if (opcode == OP_ADD || opcode == OP_SUB) begin
                    dec.eu = 1'b1;
                    dec.la = 1'b1;
                    dec.su = (opcode == OP_SUB);
                end
            end
            default: ;
        endcase
    end

    // halt latch, sets at the edge that ends T4 of HLT
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (dec.hlt) begin
            halted <= 1'b1;
        end
    end

    assign ctrl = halted ? CTRL_IDLE : dec;  // everything idles after halt

    // single bus driver per state, checked across the decoder and the halt gate
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.ep, ctrl.ce, ctrl.ei, ctrl.ea, ctrl.eu}))
        else $error("more than one bus driver enabled");

    assert property (@(posedge clk) disable iff (rst)
        ring inside {T1, T2, T3, T4, T5, T6})
        else $error("ring left the T1..T6 range");

    // halt is permanent and silences every control line
    assert property (@(posedge clk) disable iff (rst)
        halted |=> halted && ctrl == CTRL_IDLE)
        else $error("control activity after halt");

endmodule

`default_nettype wire

/* design/program_counter.sv */
// 4-bit pc with count, jump load and bus offer
`timescale 1ns/100ps
`default_nettype none

module program_counter import cpu_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire ctrl_word_t ctrl,   // uses cp and lp only
    input  wire byte_t bus,         // jump target in the low nibble
    output addr_t      pc_value     // datapath puts this on the bus when ep is high
);

    addr_t pc;

    // load beats count when both are raised
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.lp) begin
            pc <= addr_t'(bus[3:0]);  // jmp
        end else if (ctrl.cp) begin
            pc <= pc + 4'd1;          // 15 rolls over to 0
        end
    end

    assign pc_value = pc;

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
// width typedefs, opcode and timing-state enums, control word struct
`default_nettype none

package cpu_pkg;

    // data widths
    typedef logic [7:0] byte_t;     // bus, memory byte or register value
    typedef logic [3:0] addr_t;     // memory address / pc value, 16 bytes of program

    // upper nibble of an instruction byte
    typedef enum logic [3:0] {
        OP_LDA = 4'd0,   // acc <- mem[addr]
        OP_ADD = 4'd1,   // acc <- acc + mem[addr]
        OP_SUB = 4'd2,   // acc <- acc - mem[addr]
        OP_JMP = 4'd3,   // pc <- addr
        OP_OUT = 4'd14,  // out <- acc
        OP_HLT = 4'd15   // stop
    } opcode_t;
    // codes 4..13 fall through as no-ops

    // ring states, one instruction per full lap
    typedef enum logic [2:0] {
        T1 = 3'd0,  // address state
        T2 = 3'd1,  // increment state
        T3 = 3'd2,  // memory state, fetch into ir
        T4 = 3'd3,  // execute states from here on
        T5 = 3'd4,
        T6 = 3'd5
    } tstate_t;

    // one bit per control line, msb first
    typedef struct packed {
        logic hlt;  // halt
        logic cp;   // pc count
        logic ep;   // pc onto bus
        logic lp;   // pc load from bus
        logic lm;   // mar load
        logic ce;   // memory read, memory onto bus
        logic li;   // ir load
        logic ei;   // ir address nibble onto bus
        logic la;   // acc load
        logic ea;   // acc onto bus
        logic su;   // subtract instead of add
        logic eu;   // adder result onto bus
        logic lb;   // b load
        logic lo;   // output register load
    } ctrl_word_t;

    // all 14 lines low
    localparam ctrl_word_t CTRL_IDLE = '0;

endpackage

`default_nettype wire
